// ==== ma_pkg.sv ====
package ma_pkg;

    localparam int DIN_WIDTH  = 16;                        // Sample and output width.
    localparam int WINDOW_LEN = 16;                        // Samples averaged.
    localparam int ADDR_WIDTH = $clog2(WINDOW_LEN);        // Delay line address.
    localparam int ACC_WIDTH  = DIN_WIDTH + ADDR_WIDTH;    // Holds a full-scale window sum.
    localparam int DIFF_WIDTH = DIN_WIDTH + 1;             // Newest minus oldest.
    localparam int FILL_WIDTH = ADDR_WIDTH + 1;            // Counts up to WINDOW_LEN.

    // Fill count at which every RAM word holds a sample written since reset.
    localparam logic [FILL_WIDTH-1:0] FILL_MAX = FILL_WIDTH'(WINDOW_LEN);

    // Remainder threshold for round to nearest, an exact half rounds down.
    localparam logic [ADDR_WIDTH-1:0] ROUND_HALF = ADDR_WIDTH'(WINDOW_LEN / 2);

    typedef enum logic {
        ROUND_TRUNC   = 1'b0,
        ROUND_NEAREST = 1'b1
    } round_mode_e;

    // Producer to delay line, one write per accepted sample.
    typedef struct packed {
        logic                        valid;
        logic signed [DIN_WIDTH-1:0] data;
        logic [ADDR_WIDTH-1:0]       addr;
        logic                        primed;   // Old word at addr is real data.
        round_mode_e                 mode;
    } ram_wr_t;

    // Delay line to comb, newest and oldest sample side by side.
    typedef struct packed {
        logic                        valid;
        logic signed [DIN_WIDTH-1:0] newest;
        logic signed [DIN_WIDTH-1:0] oldest;   // Zero while the window fills.
        round_mode_e                 mode;
    } comb_pair_t;

endpackage

// ==== ma_sample_front.sv ====
`timescale 1ns/100ps

module ma_sample_front (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [ma_pkg::DIN_WIDTH-1:0]   in_sample,
    input  logic                                  in_valid,
    input  ma_pkg::round_mode_e                   round_mode,
    output ma_pkg::ram_wr_t                       wr
);

    logic [ma_pkg::ADDR_WIDTH-1:0] wr_addr;      // Next RAM word to overwrite.
    logic [ma_pkg::FILL_WIDTH-1:0] fill_cnt;     // Samples written since reset.
    logic                          window_full;

    // Once WINDOW_LEN samples are in, every address holds a real sample.
    assign window_full = (fill_cnt == ma_pkg::FILL_MAX);

    always_ff @(posedge clk) begin
        // Payload follows the strobe, held otherwise.
        if (in_valid) begin
            wr.data   <= in_sample;
            wr.addr   <= wr_addr;
            wr.primed <= window_full;
            wr.mode   <= round_mode;
        end

        if (rst) begin
            wr.valid <= 1'b0;
            wr_addr  <= '0;
            fill_cnt <= '0;
        end else begin
            wr.valid <= in_valid;                 // One cycle to the delay line.
            if (in_valid) begin
                wr_addr <= wr_addr + 1'b1;        // Wraps at WINDOW_LEN.
                if (!window_full) begin
                    fill_cnt <= fill_cnt + 1'b1;  // Saturates at FILL_MAX.
                end
            end
        end
    end

endmodule

// ==== ma_delay_ram.sv ====
`timescale 1ns/100ps

module ma_delay_ram (
    input  logic                clk,
    input  logic                rst,
    input  ma_pkg::ram_wr_t     wr,
    output ma_pkg::comb_pair_t  pair
);

    // Delay line storage, one word per window slot.
    logic signed [ma_pkg::DIN_WIDTH-1:0] mem [0:ma_pkg::WINDOW_LEN-1];

    logic signed [ma_pkg::DIN_WIDTH-1:0] rd_q;    // RAM read register.
    logic signed [ma_pkg::DIN_WIDTH-1:0] old_q;   // Read output register.

    // First stage alongside the RAM read.
    logic                                s1_valid;
    logic signed [ma_pkg::DIN_WIDTH-1:0] s1_newest;
    logic                                s1_primed;
    ma_pkg::round_mode_e                 s1_mode;

    // Second stage alongside the output register.
    logic                                s2_valid;
    logic signed [ma_pkg::DIN_WIDTH-1:0] s2_newest;
    logic                                s2_primed;
    ma_pkg::round_mode_e                 s2_mode;

    // Read-first, the word returned is WINDOW_LEN samples old.
    always_ff @(posedge clk) begin
        if (wr.valid) begin
            rd_q          <= mem[wr.addr];
            mem[wr.addr]  <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            old_q <= rd_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            s1_newest <= '0;
            s1_primed <= 1'b0;
            s1_mode   <= ma_pkg::ROUND_TRUNC;
            s2_valid  <= 1'b0;
            s2_newest <= '0;
            s2_primed <= 1'b0;
            s2_mode   <= ma_pkg::ROUND_TRUNC;
        end else begin
            s1_valid <= wr.valid;
            s2_valid <= s1_valid;
            if (wr.valid) begin
                s1_newest <= wr.data;
                s1_primed <= wr.primed;
                s1_mode   <= wr.mode;
            end
            if (s1_valid) begin
                s2_newest <= s1_newest;
                s2_primed <= s1_primed;
                s2_mode   <= s1_mode;
            end
        end
    end

    always_comb begin
        pair.valid  = s2_valid;
        pair.newest = s2_newest;
        pair.mode   = s2_mode;
        // Stale RAM content counts as zero until the window has filled.
        if (s2_primed) begin
            pair.oldest = old_q;
        end else begin
            pair.oldest = '0;
        end
    end

endmodule

// ==== ma_comb_integ.sv ====
`timescale 1ns/100ps

module ma_comb_integ (
    input  logic                                  clk,
    input  logic                                  rst,
    input  ma_pkg::comb_pair_t                    pair,
    output logic signed [ma_pkg::DIN_WIDTH-1:0]   out_sample,
    output logic                                  out_valid
);

    // Comb stage.
    logic signed [ma_pkg::DIFF_WIDTH-1:0] diff_q;
    logic                                 diff_valid;
    ma_pkg::round_mode_e                  diff_mode;

    // Integrator stage.
    logic signed [ma_pkg::ACC_WIDTH-1:0]  acc_q;       // Running window sum.
    logic                                 acc_valid;
    ma_pkg::round_mode_e                  acc_mode;

    // Scaling.
    logic signed [ma_pkg::DIN_WIDTH-1:0]  quot;        // Floor of sum / WINDOW_LEN.
    logic [ma_pkg::ADDR_WIDTH-1:0]        rem;         // Bits shifted out.
    logic                                 round_up;

    always_ff @(posedge clk) begin
        if (pair.valid) begin
            // Both operands sign extended, full-scale swing fits in DIFF_WIDTH.
            diff_q    <= ma_pkg::DIFF_WIDTH'(pair.newest)
                         - ma_pkg::DIFF_WIDTH'(pair.oldest);
            diff_mode <= pair.mode;
        end

        if (rst) begin
            diff_valid <= 1'b0;
        end else begin
            diff_valid <= pair.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q     <= '0;
            acc_valid <= 1'b0;
            acc_mode  <= ma_pkg::ROUND_TRUNC;
        end else begin
            acc_valid <= diff_valid;
            if (diff_valid) begin
                acc_q    <= acc_q + ma_pkg::ACC_WIDTH'(diff_q);  // Sign extended add.
                acc_mode <= diff_mode;                           // Mode of this sample.
            end
        end
    end

    // Arithmetic shift by ADDR_WIDTH is the upper DIN_WIDTH bits.
    assign quot = acc_q[ma_pkg::ACC_WIDTH-1 -: ma_pkg::DIN_WIDTH];
    assign rem  = acc_q[ma_pkg::ADDR_WIDTH-1:0];

    // Strictly above half, so a tie keeps the truncated value.
    assign round_up = (acc_mode == ma_pkg::ROUND_NEAREST) && (rem > ma_pkg::ROUND_HALF);

    always_comb begin
        if (round_up) begin
            out_sample = quot + 1'b1;   // Cannot wrap, max sum has zero remainder.
        end else begin
            out_sample = quot;
        end
    end

    assign out_valid = acc_valid;

endmodule

// ==== ma_filter_top.sv ====
`timescale 1ns/100ps

module ma_filter_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [ma_pkg::DIN_WIDTH-1:0]   in_sample,
    input  logic                                  in_valid,
    input  ma_pkg::round_mode_e                   round_mode,
    output logic signed [ma_pkg::DIN_WIDTH-1:0]   out_sample,
    output logic                                  out_valid
);

    ma_pkg::ram_wr_t    wr;     // Sample with its write slot.
    ma_pkg::comb_pair_t pair;   // Newest and oldest, aligned.

    // Capture, write address and fill state.
    ma_sample_front u_front (
        .clk        (clk),
        .rst        (rst),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .round_mode (round_mode),
        .wr         (wr)
    );

    // WINDOW_LEN deep delay line.
    ma_delay_ram u_delay (
        .clk  (clk),
        .rst  (rst),
        .wr   (wr),
        .pair (pair)
    );

    // Comb, integrator and rounding.
    ma_comb_integ u_integ (
        .clk        (clk),
        .rst        (rst),
        .pair       (pair),
        .out_sample (out_sample),
        .out_valid  (out_valid)
    );

endmodule

// ==== ma_checker.sv ====
`timescale 1ns/100ps

module ma_checker (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic signed [ma_pkg::DIN_WIDTH-1:0]   in_sample,
    input  logic                                  in_valid,
    input  ma_pkg::round_mode_e                   round_mode,
    input  logic signed [ma_pkg::DIN_WIDTH-1:0]   out_sample,
    input  logic                                  out_valid,
    input  logic                                  end_run,
    output int                                    mismatch_count,
    output int                                    protocol_count,
    output int                                    check_count,
    output int                                    pending,
    output logic                                  report_done
);

    localparam int LATENCY = 5;        // Rising edges from input strobe to output pulse.

    int   hist [ma_pkg::WINDOW_LEN];   // Last WINDOW_LEN accepted samples.
    int   hist_ptr    = 0;
    int   expect_q [$];                // Expected outputs in input order.
    int   due_q [$];                   // Edge count at which each output is due.
    int   edge_cnt    = 0;
    int   n_mismatch  = 0;
    int   n_protocol  = 0;
    int   n_checked   = 0;
    int   n_pending   = 0;
    logic done_flag   = 1'b0;

    assign mismatch_count = n_mismatch;
    assign protocol_count = n_protocol;
    assign check_count    = n_checked;
    assign pending        = n_pending;
    assign report_done    = done_flag;

    // Floor of the window sum over WINDOW_LEN, then the optional round up.
    function automatic int expected_average(input int sum, input ma_pkg::round_mode_e mode);
        int quo;
        int rem;
        quo = sum / ma_pkg::WINDOW_LEN;           // Rounds toward zero.
        rem = sum - quo * ma_pkg::WINDOW_LEN;
        if (rem < 0) begin
            quo = quo - 1;                        // Move to floor for negative sums.
            rem = rem + ma_pkg::WINDOW_LEN;
        end
        if (mode == ma_pkg::ROUND_NEAREST && rem > ma_pkg::WINDOW_LEN / 2) begin
            quo = quo + 1;                        // Exact half stays down.
        end
        return quo;
    endfunction

    // Empty history and nothing in flight.
    task automatic clear_model();
        for (int i = 0; i < ma_pkg::WINDOW_LEN; i++) begin
            hist[i] = 0;
        end
        hist_ptr = 0;
        expect_q.delete();
        due_q.delete();
    endtask

    always @(posedge clk) begin
        int sum;
        int exp_val;
        int due_edge;

        edge_cnt++;

        // Output seen before this edge belongs to a sample accepted earlier.
        if (out_valid) begin
            if (expect_q.size() == 0) begin
                $display("Error at %0d ns: out_valid high with no sample outstanding", $time);
                n_protocol++;
            end else begin
                exp_val  = expect_q.pop_front();
                due_edge = due_q.pop_front();
                n_checked++;
                if (int'(out_sample) != exp_val) begin
                    $display("Fail at %0d ns: out_sample expected %0d, actual %0d",
                             $time, exp_val, out_sample);
                    n_mismatch++;
                end
                if (edge_cnt != due_edge) begin
                    $display("Error at %0d ns: output %0d cycles after its sample, expected %0d",
                             $time, edge_cnt - due_edge + LATENCY, LATENCY);
                    n_protocol++;
                end
            end
        end

        if (rst) begin
            clear_model();                        // Samples in flight are dropped.
        end else if (in_valid) begin
            hist[hist_ptr] = int'(in_sample);
            hist_ptr       = (hist_ptr + 1) % ma_pkg::WINDOW_LEN;
            sum = 0;
            for (int i = 0; i < ma_pkg::WINDOW_LEN; i++) begin
                sum += hist[i];
            end
            expect_q.push_back(expected_average(sum, round_mode));
            due_q.push_back(edge_cnt + LATENCY);
        end

        if (end_run && !done_flag) begin
            if (expect_q.size() != 0) begin
                $display("Error at end of run: %0d samples never produced an output",
                         expect_q.size());
                n_protocol++;
            end
            done_flag <= 1'b1;
        end

        n_pending = expect_q.size();
    end

endmodule

// ==== tb_ma_filter.sv ====
`timescale 1ns/100ps

module tb_ma_filter;

    localparam int RANDOM_SAMPLES = 2000;
    localparam int BURST_SAMPLES  = 12;   // Back to back samples still in flight at reset.
    localparam int AFTER_RESET    = 50;
    localparam int RANGE_RUN      = 40;   // Longer than the window.
    localparam int VALID_PERCENT  = 70;
    // About 3100 cycles of traffic and drain plus margin.
    localparam int MAX_CYCLES     = 6000;

    localparam logic signed [ma_pkg::DIN_WIDTH-1:0] MIN_SAMPLE =
        {1'b1, {(ma_pkg::DIN_WIDTH-1){1'b0}}};
    localparam logic signed [ma_pkg::DIN_WIDTH-1:0] MAX_SAMPLE =
        {1'b0, {(ma_pkg::DIN_WIDTH-1){1'b1}}};

    logic                                clk;
    logic                                rst;
    logic signed [ma_pkg::DIN_WIDTH-1:0] in_sample;
    logic                                in_valid;
    ma_pkg::round_mode_e                 round_mode;
    logic signed [ma_pkg::DIN_WIDTH-1:0] out_sample;
    logic                                out_valid;

    logic end_run;
    int   mismatch_count;
    int   protocol_count;
    int   check_count;
    int   pending;
    logic report_done;

    int                  cycle_count;
    int                  mode_left;     // Samples left in the current mode block.
    ma_pkg::round_mode_e cur_mode;

    ma_filter_top DUT (
        .clk        (clk),
        .rst        (rst),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .round_mode (round_mode),
        .out_sample (out_sample),
        .out_valid  (out_valid)
    );

    ma_checker u_checker (
        .clk            (clk),
        .rst            (rst),
        .in_sample      (in_sample),
        .in_valid       (in_valid),
        .round_mode     (round_mode),
        .out_sample     (out_sample),
        .out_valid      (out_valid),
        .end_run        (end_run),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count),
        .check_count    (check_count),
        .pending        (pending),
        .report_done    (report_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // New mode every 20 to 99 samples.
    task automatic next_mode();
        if (mode_left == 0) begin
            cur_mode  = ($urandom() % 2 == 0) ? ma_pkg::ROUND_TRUNC : ma_pkg::ROUND_NEAREST;
            mode_left = 20 + int'($urandom() % 80);
        end
        mode_left--;
    endtask

    task automatic drive_sample(input logic signed [ma_pkg::DIN_WIDTH-1:0] value);
        @(posedge clk);
        next_mode();
        in_valid   <= 1'b1;
        in_sample  <= value;
        round_mode <= cur_mode;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        in_valid  <= 1'b0;
        in_sample <= ma_pkg::DIN_WIDTH'($urandom());   // Must be ignored.
    endtask

    task automatic send_random(input int count);
        int sent;
        sent = 0;
        while (sent < count) begin
            if ($urandom() % 100 < VALID_PERCENT) begin
                drive_sample(ma_pkg::DIN_WIDTH'($urandom()));
                sent++;
            end else begin
                drive_idle();
            end
        end
    endtask

    task automatic send_const(input logic signed [ma_pkg::DIN_WIDTH-1:0] value, input int count);
        repeat (count) drive_sample(value);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(82647));
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_sample  = '0;
        round_mode = ma_pkg::ROUND_TRUNC;
        end_run    = 1'b0;
        mode_left  = 0;
        cur_mode   = ma_pkg::ROUND_TRUNC;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        $display("Phase 1: %0d random samples with gaps", RANDOM_SAMPLES);
        send_random(RANDOM_SAMPLES);

        $display("Phase 2: reset with samples in flight");
        repeat (BURST_SAMPLES) drive_sample(ma_pkg::DIN_WIDTH'($urandom()));
        pulse_reset();
        send_random(AFTER_RESET);

        $display("Phase 3: full-scale samples");
        send_const(MIN_SAMPLE, RANGE_RUN);
        send_const(MAX_SAMPLE, RANGE_RUN);
        send_const(MIN_SAMPLE, RANGE_RUN);
        drive_idle();

        // Let the pipeline drain, then watch a few idle cycles for strays.
        while (pending != 0) drive_idle();
        repeat (8) drive_idle();
        @(posedge clk);
        end_run <= 1'b1;
        while (!report_done) @(posedge clk);

        $display("Summary: %0d outputs checked, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0 && check_count > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== all.f ====
ma_pkg.sv
ma_sample_front.sv
ma_delay_ram.sv
ma_comb_integ.sv
ma_filter_top.sv
ma_checker.sv
tb_ma_filter.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_ma_filter
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides the result, the simulator status alone is not enough.
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
